// File: Makefile
VERILATOR  ?= verilator
SIM_FLAGS  ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= board_tb
RTL_TOP    ?= board_top
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "All tests passed!" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: board_pkg.sv
package board_pkg;

    typedef logic [31:0] word_t;     // apb data and load buffer word
    typedef logic [7:0]  paddr_t;    // apb byte address
    typedef logic [7:0]  led_t;      // one led bank or one segment pattern
    typedef logic [4:0]  key_idx_t;  // 0..15 keys, 16 none
    typedef logic [3:0]  load_idx_t;

    localparam int       LOAD_DEPTH = 16;
    localparam key_idx_t KEY_NONE   = 5'd16;

    typedef struct packed {
        logic   psel;
        logic   penable;
        logic   pwrite;
        paddr_t paddr;
        word_t  pwdata;
    } apb_req_t;

    typedef struct packed {
        word_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic      valid;
        load_idx_t idx;
        word_t     data;
    } load_wr_t;

    localparam paddr_t ADDR_LED  = 8'h00;
    localparam paddr_t ADDR_SEG  = 8'h04;
    localparam paddr_t ADDR_SW   = 8'h08;
    localparam paddr_t ADDR_BTN  = 8'h0C;
    localparam paddr_t ADDR_KEY  = 8'h10;
    localparam paddr_t ADDR_STAT = 8'h14;
    localparam paddr_t ADDR_BUF  = 8'h40;  // window up to 0x7C

    // active low, bit order {dp, g, f, e, d, c, b, a}
    localparam led_t HEX_SEG [16] = '{
        8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
        8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E
    };

endpackage

// File: board_tb.sv
module board_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLKS_PER_BIT    = 8;
    localparam int SCAN_CYCLES     = 4;
    localparam int DEBOUNCE_CYCLES = 2;
    localparam int KEY_POLLS       = 100;  // apb reads before giving up on a key
    localparam int DONE_POLLS      = 400;

    // active low {dp, g, f, e, d, c, b, a} with dp off
    localparam logic [7:0] SEG_TABLE [16] = '{
        8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
        8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E
    };

    logic                clk;
    logic                arst_n;
    board_pkg::apb_req_t apb_req;
    board_pkg::apb_rsp_t apb_rsp;
    logic                rx;
    logic [7:0]          switches1;
    logic [7:0]          switches2;
    logic [7:0]          switches3;
    logic                bt1;
    logic                bt2;
    logic                bt3;
    logic                bt4;
    logic                bt5;
    logic [3:0]          kp_row;
    logic [3:0]          kp_col;
    board_pkg::led_t     led1_out;
    board_pkg::led_t     led2_out;
    board_pkg::led_t     led3_out;
    board_pkg::led_t     seg_en;
    board_pkg::led_t     seg_out;
    logic                uart_done;

    board_pkg::key_idx_t key_down;     // key held on the matrix model
    logic [23:0]         exp_led;
    board_pkg::word_t    exp_seg_val;
    board_pkg::word_t    exp_rdata;
    logic                exp_err;
    logic                chk_data;     // compare prdata in this access phase
    logic                chk_err;
    integer              seed;
    int unsigned         scan_ticks;   // clocks since reset release

    tb_clk_gen i_clk_gen (.clk);

    board_top #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .SCAN_CYCLES(SCAN_CYCLES),
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) i_board_top (
        .clk, .arst_n, .apb_req, .apb_rsp, .rx,
        .switches1, .switches2, .switches3,
        .bt1, .bt2, .bt3, .bt4, .bt5,
        .kp_row, .kp_col,
        .led1_out, .led2_out, .led3_out, .seg_en, .seg_out, .uart_done
    );

    // column pulled low while the key's row is driven
    always_comb begin
        kp_col = 4'hF;
        if ((key_down != board_pkg::KEY_NONE) && !kp_row[key_down[3:2]]) begin
            kp_col[key_down[1:0]] = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scan_ticks <= 0;
        end else begin
            scan_ticks <= scan_ticks + 1;
        end
    end

    function automatic logic [7:0] seg_for(input logic [7:0] en, input logic [31:0] val);
        logic [3:0] nib;
        nib = 4'd0;
        for (int d = 0; d < 8; d++) begin
            if (!en[d]) begin
                nib = val[4*d +: 4];
            end
        end
        return SEG_TABLE[nib];
    endfunction

    // digit steps once per SCAN_CYCLES clocks, starting on digit 0
    function automatic logic [7:0] digit_enable(input int unsigned ticks);
        logic [7:0] en;
        en = 8'hFF;
        en[(ticks / SCAN_CYCLES) % 8] = 1'b0;
        return en;
    endfunction

    task automatic stop_on_failure();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        $display("[ERROR] t=%0t %s: got 0x%h, expected 0x%h", $time, name, got, exp);
        stop_on_failure();
    endtask

    task automatic timeout_error(input string what);
        $display("timeout: %s at t=%0t", what, $time);
        stop_on_failure();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else value_error(name, got, exp);
    endtask

    a_prdata: assert property (@(posedge clk) disable iff (!arst_n)
        (apb_req.penable && chk_data) |-> (apb_rsp.prdata == exp_rdata))
        else value_error("prdata", $sampled(apb_rsp.prdata), $sampled(exp_rdata));

    a_pslverr: assert property (@(posedge clk) disable iff (!arst_n)
        (apb_req.penable && chk_err) |-> (apb_rsp.pslverr == exp_err))
        else value_error("pslverr", 32'($sampled(apb_rsp.pslverr)), 32'($sampled(exp_err)));

    a_pready: assert property (@(posedge clk) disable iff (!arst_n)
        apb_req.penable |-> apb_rsp.pready)
        else value_error("pready", 32'($sampled(apb_rsp.pready)), 32'd1);

    a_leds: assert property (@(posedge clk) disable iff (!arst_n)
        {led3_out, led2_out, led1_out} == exp_led)
        else value_error("led_out", 32'($sampled({led3_out, led2_out, led1_out})),
                         32'($sampled(exp_led)));

    a_seg_en: assert property (@(posedge clk) disable iff (!arst_n)
        seg_en == digit_enable(scan_ticks))
        else value_error("seg_en", 32'($sampled(seg_en)),
                         32'(digit_enable($sampled(scan_ticks))));

    a_seg: assert property (@(posedge clk) disable iff (!arst_n)
        seg_out == seg_for(seg_en, exp_seg_val))
        else value_error("seg_out", 32'($sampled(seg_out)),
                         32'(seg_for($sampled(seg_en), $sampled(exp_seg_val))));

    // one transfer starting 1 ns after a rising edge
    task automatic apb_xfer(input board_pkg::paddr_t addr, input logic write,
                            input board_pkg::word_t wdata, output board_pkg::word_t rdata);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;  // access phase
        #1;
        rdata = apb_rsp.prdata;
        @(posedge clk);
        #1;
        apb_req  = '0;
        chk_data = 1'b0;
        chk_err  = 1'b0;
        if (write && (addr == board_pkg::ADDR_LED)) begin
            exp_led = wdata[23:0];
        end
        if (write && (addr == board_pkg::ADDR_SEG)) begin
            exp_seg_val = wdata;
        end
    endtask

    task automatic check_read(input board_pkg::paddr_t addr, input board_pkg::word_t exp);
        board_pkg::word_t rd;
        exp_rdata = exp;
        exp_err   = 1'b0;
        chk_data  = 1'b1;
        chk_err   = 1'b1;
        apb_xfer(addr, 1'b0, '0, rd);
    endtask

    task automatic check_write(input board_pkg::paddr_t addr, input board_pkg::word_t data,
                               input logic err);
        board_pkg::word_t rd;
        exp_err = err;
        chk_err = 1'b1;
        apb_xfer(addr, 1'b1, data, rd);
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};  // stop, data lsb first, start
        for (int i = 0; i < 10; i++) begin
            rx = frame[i];
            repeat (CLKS_PER_BIT) @(posedge clk);
            #1;
        end
    endtask

    task automatic uart_load(input int n);
        board_pkg::word_t words[$];
        board_pkg::word_t w;
        int               polls;
        send_byte(8'(n));
        check_value("uart_done", 32'(uart_done), 32'd0);  // a new count restarts the load
        for (int i = 0; i < n; i++) begin
            w = $random(seed);
            words.push_back(w);
            for (int b = 0; b < 4; b++) begin
                send_byte(w[8*b +: 8]);
            end
        end
        polls = 0;
        while (!uart_done) begin
            if (polls == DONE_POLLS) timeout_error("uart load never reported done");
            polls++;
            @(posedge clk);
            #1;
        end
        check_read(board_pkg::ADDR_STAT, {19'd0, 5'(n), 7'd0, 1'b1});
        for (int i = 0; i < n; i++) begin
            check_read(board_pkg::ADDR_BUF + 8'(4 * i), words[i]);
        end
    endtask

    task automatic wait_key(input board_pkg::key_idx_t exp);
        board_pkg::word_t rd;
        int               polls;
        polls = 0;
        apb_xfer(board_pkg::ADDR_KEY, 1'b0, '0, rd);
        while (rd[4:0] != exp) begin
            if (polls == KEY_POLLS) timeout_error("key index never settled");
            polls++;
            apb_xfer(board_pkg::ADDR_KEY, 1'b0, '0, rd);
        end
        check_read(board_pkg::ADDR_KEY, 32'(exp));
    endtask

    initial begin
        board_pkg::word_t w;
        seed        = 32'hc7c4_daa1;
        arst_n      = 1'b0;
        apb_req     = '0;
        rx          = 1'b1;
        {switches3, switches2, switches1} = '0;
        {bt5, bt4, bt3, bt2, bt1} = '0;
        key_down    = board_pkg::KEY_NONE;
        exp_led     = '0;
        exp_seg_val = '0;
        exp_rdata   = '0;
        exp_err     = 1'b0;
        chk_data    = 1'b0;
        chk_err     = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;

        check_value("uart_done", 32'(uart_done), 32'd0);
        check_read(board_pkg::ADDR_KEY, 32'(board_pkg::KEY_NONE));
        check_read(board_pkg::ADDR_STAT, 32'd0);

        for (int i = 0; i < 4; i++) begin
            w = $random(seed);
            check_write(board_pkg::ADDR_LED, w, 1'b0);
            check_read(board_pkg::ADDR_LED, {8'h00, w[23:0]});
            w = $random(seed);
            check_write(board_pkg::ADDR_SEG, w, 1'b0);
            check_read(board_pkg::ADDR_SEG, w);
            repeat (8 * SCAN_CYCLES) @(posedge clk);  // one full display sweep
            #1;
        end
        check_write(board_pkg::ADDR_SW, $random(seed), 1'b1);
        check_write(8'h24, $random(seed), 1'b1);   // unmapped
        check_write(board_pkg::ADDR_BUF, $random(seed), 1'b1);
        check_read(board_pkg::ADDR_LED, {8'h00, exp_led});
        check_read(board_pkg::ADDR_SEG, exp_seg_val);

        for (int i = 0; i < 4; i++) begin
            {switches3, switches2, switches1} = 24'($random(seed));
            {bt5, bt4, bt3, bt2, bt1} = 5'($random(seed));
            repeat (2) @(posedge clk);  // synchronizer depth
            #1;
            check_read(board_pkg::ADDR_SW, {8'h00, switches3, switches2, switches1});
            check_read(board_pkg::ADDR_BTN, {27'd0, bt5, bt4, bt3, bt2, bt1});
        end

        for (int i = 0; i < 2; i++) begin
            uart_load(int'($unsigned($random(seed)) % 16) + 1);
        end

        for (int k = 0; k < 16; k++) begin
            key_down = 5'(k);
            wait_key(5'(k));
            key_down = board_pkg::KEY_NONE;
            wait_key(board_pkg::KEY_NONE);
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

// File: board_top.sv
module board_top #(
    parameter int CLKS_PER_BIT    = 868,
    parameter int SCAN_CYCLES     = 100000,
    parameter int DEBOUNCE_CYCLES = 4
) (
    input  logic                clk,
    input  logic                arst_n,
    input  board_pkg::apb_req_t apb_req,
    output board_pkg::apb_rsp_t apb_rsp,
    input  logic                rx,
    input  logic [7:0]          switches1,
    input  logic [7:0]          switches2,
    input  logic [7:0]          switches3,
    input  logic                bt1,
    input  logic                bt2,
    input  logic                bt3,
    input  logic                bt4,
    input  logic                bt5,
    output logic [3:0]          kp_row,
    input  logic [3:0]          kp_col,
    output board_pkg::led_t     led1_out,
    output board_pkg::led_t     led2_out,
    output board_pkg::led_t     led3_out,
    output board_pkg::led_t     seg_en,
    output board_pkg::led_t     seg_out,
    output logic                uart_done
);

    board_pkg::load_wr_t load_wr;
    board_pkg::key_idx_t key_idx;
    board_pkg::word_t    seg_value;
    logic [4:0]          word_cnt;

    uart_loader #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_loader_inst (
        .clk, .arst_n, .rx, .load_wr, .done(uart_done), .word_cnt
    );

    seg7_scan #(.SCAN_CYCLES(SCAN_CYCLES)) seg7_scan_inst (
        .clk, .arst_n, .value(seg_value), .seg_en, .seg_out
    );

    keypad_scan #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) keypad_scan_inst (
        .clk, .arst_n, .kp_col, .kp_row, .key_idx
    );

    io_regs io_regs_inst (
        .clk, .arst_n, .apb_req, .apb_rsp,
        .switches1, .switches2, .switches3,
        .bt1, .bt2, .bt3, .bt4, .bt5,
        .key_idx, .load_wr, .done(uart_done), .word_cnt,
        .led1_out, .led2_out, .led3_out, .seg_value
    );

endmodule

// File: io_regs.sv
module io_regs (
    input  logic                clk,
    input  logic                arst_n,
    input  board_pkg::apb_req_t apb_req,
    output board_pkg::apb_rsp_t apb_rsp,
    input  logic [7:0]          switches1,
    input  logic [7:0]          switches2,
    input  logic [7:0]          switches3,
    input  logic                bt1,
    input  logic                bt2,
    input  logic                bt3,
    input  logic                bt4,
    input  logic                bt5,
    input  board_pkg::key_idx_t key_idx,
    input  board_pkg::load_wr_t load_wr,
    input  logic                done,
    input  logic [4:0]          word_cnt,
    output board_pkg::led_t     led1_out,
    output board_pkg::led_t     led2_out,
    output board_pkg::led_t     led3_out,
    output board_pkg::word_t    seg_value
);

    logic [28:0]          in_meta;   // {buttons, switches}
    logic [28:0]          in_sync;
    board_pkg::word_t     load_buf [board_pkg::LOAD_DEPTH];
    board_pkg::paddr_t    addr;
    board_pkg::load_idx_t buf_idx;
    board_pkg::word_t     rdata;
    logic                 access;
    logic                 is_buf;
    logic                 mapped;
    logic                 read_only;
    logic                 wr_en;

    assign addr    = apb_req.paddr;
    assign buf_idx = addr[5:2];
    assign access  = apb_req.psel && apb_req.penable;
    assign is_buf  = (addr[7:6] == board_pkg::ADDR_BUF[7:6]) && (addr[1:0] == 2'b00);

    always_comb begin
        mapped    = 1'b1;
        read_only = 1'b1;
        rdata     = '0;
        case (addr)
            board_pkg::ADDR_LED: begin
                read_only = 1'b0;
                rdata     = {8'h00, led3_out, led2_out, led1_out};
            end
            board_pkg::ADDR_SEG: begin
                read_only = 1'b0;
                rdata     = seg_value;
            end
            board_pkg::ADDR_SW:   rdata = {8'h00, in_sync[23:0]};
            board_pkg::ADDR_BTN:  rdata = {27'd0, in_sync[28:24]};
            board_pkg::ADDR_KEY:  rdata = {27'd0, key_idx};
            board_pkg::ADDR_STAT: rdata = {19'd0, word_cnt, 7'd0, done};
            default: begin
                if (is_buf) begin
                    rdata = load_buf[buf_idx];
                end else begin
                    mapped = 1'b0;
                end
            end
        endcase
    end

    assign wr_en = access && apb_req.pwrite && mapped && !read_only;

    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1;  // no wait states
    assign apb_rsp.pslverr = access && (!mapped || (apb_req.pwrite && read_only));

    // two-flop synchronizer for switches and buttons
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_meta <= '0;
            in_sync <= '0;
        end else begin
            in_meta <= {bt5, bt4, bt3, bt2, bt1, switches3, switches2, switches1};
            in_sync <= in_meta;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            led1_out  <= '0;
            led2_out  <= '0;
            led3_out  <= '0;
            seg_value <= '0;
        end else if (wr_en) begin
            if (addr == board_pkg::ADDR_LED) begin
                {led3_out, led2_out, led1_out} <= apb_req.pwdata[23:0];
            end
            if (addr == board_pkg::ADDR_SEG) begin
                seg_value <= apb_req.pwdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_wr.valid) begin
            load_buf[load_wr.idx] <= load_wr.data;
        end
    end

    a_penable_needs_psel: assert property (
        @(posedge clk) disable iff (!arst_n) apb_req.penable |-> apb_req.psel
    );

endmodule

// File: keypad_scan.sv
module keypad_scan #(
    parameter int DEBOUNCE_CYCLES = 4
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic [3:0]          kp_col,
    output logic [3:0]          kp_row,
    output board_pkg::key_idx_t key_idx
);

    localparam int               DEB_W = $clog2(DEBOUNCE_CYCLES + 1);
    localparam logic [DEB_W-1:0] DEB_N = DEB_W'(DEBOUNCE_CYCLES);

    logic [3:0]          col_meta;
    logic [3:0]          col_s;
    logic [1:0]          row;
    logic [1:0]          hold_cnt;   // each row is held four cycles
    logic                sample;
    logic                hit;
    logic [1:0]          first_col;
    board_pkg::key_idx_t cand;       // first key seen in this sweep
    board_pkg::key_idx_t next_cand;
    board_pkg::key_idx_t last_key;   // reading of the previous sweep
    logic [DEB_W-1:0]    stable_cnt;

    assign kp_row = ~(4'b0001 << row);
    // columns have passed the synchronizer by the last hold cycle
    assign sample = (hold_cnt == 2'd3);

    always_comb begin
        hit       = 1'b0;
        first_col = 2'd0;
        for (int c = 3; c >= 0; c--) begin
            if (!col_s[c]) begin
                hit       = 1'b1;
                first_col = 2'(c);  // lowest column wins
            end
        end
        next_cand = cand;
        if ((cand == board_pkg::KEY_NONE) && hit) begin
            next_cand = {1'b0, row, first_col};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            col_meta <= 4'hF;
            col_s    <= 4'hF;
        end else begin
            col_meta <= kp_col;
            col_s    <= col_meta;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            row        <= '0;
            hold_cnt   <= '0;
            cand       <= board_pkg::KEY_NONE;
            last_key   <= board_pkg::KEY_NONE;
            stable_cnt <= '0;
            key_idx    <= board_pkg::KEY_NONE;
        end else begin
            hold_cnt <= hold_cnt + 1'b1;
            if (sample) begin
                row <= row + 1'b1;
                if (row == 2'd3) begin
                    // sweep complete
                    cand <= board_pkg::KEY_NONE;
                    if (next_cand != last_key) begin
                        last_key   <= next_cand;
                        stable_cnt <= DEB_W'(1);
                    end else if (stable_cnt != DEB_N) begin
                        stable_cnt <= stable_cnt + 1'b1;
                    end
                end else begin
                    cand <= next_cand;
                end
            end
            if (stable_cnt == DEB_N) begin
                key_idx <= last_key;
            end
        end
    end

    a_one_row: assert property (
        @(posedge clk) disable iff (!arst_n) $onehot(~kp_row)
    );

endmodule

// File: project.f
board_pkg.sv
uart_loader.sv
seg7_scan.sv
keypad_scan.sv
io_regs.sv
board_top.sv
tb_clk_gen.sv
board_tb.sv

// File: seg7_scan.sv
module seg7_scan #(
    parameter int SCAN_CYCLES = 100000
) (
    input  logic             clk,
    input  logic             arst_n,
    input  board_pkg::word_t value,
    output board_pkg::led_t  seg_en,
    output board_pkg::led_t  seg_out
);

    localparam int               CNT_W    = $clog2(SCAN_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SCAN_CYCLES - 1);

    logic [CNT_W-1:0] cnt;
    logic [2:0]       digit;   // 0 is the rightmost digit
    logic [3:0]       nibble;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt   <= '0;
            digit <= '0;
        end else begin
            if (cnt == CNT_LAST) begin
                cnt   <= '0;
                digit <= digit + 1'b1;  // wraps 7 -> 0
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    assign nibble  = value[{digit, 2'b00} +: 4];
    assign seg_en  = ~(8'b0000_0001 << digit);      // active low enable
    assign seg_out = board_pkg::HEX_SEG[nibble];

    // exactly one digit lit at any time
    a_one_digit: assert property (
        @(posedge clk) disable iff (!arst_n) $onehot(~seg_en)
    );

endmodule

// File: tb_clk_gen.sv
module tb_clk_gen (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;  // 4 ns period

endmodule

// File: uart_loader.sv
module uart_loader #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                rx,
    output board_pkg::load_wr_t load_wr,
    output logic                done,
    output logic [4:0]          word_cnt
);

    localparam int               CNT_W     = $clog2(CLKS_PER_BIT) + 1;
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {ST_IDLE, ST_START, ST_DATA, ST_STOP} rx_state_e;
    typedef enum logic {PH_COUNT, PH_PAYLOAD} phase_e;

    rx_state_e        state;
    phase_e           phase;
    logic [1:0]       rx_sync;
    logic             rx_s;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       rx_byte;
    logic             byte_done;
    logic [4:0]       n_words;
    logic [1:0]       byte_cnt;
    logic [23:0]      word_sh;   // low three bytes of the word in flight

    assign rx_s = rx_sync[1];
    // stop bit sampled high, byte is good
    assign byte_done = (state == ST_STOP) && (clk_cnt == BIT_LAST) && rx_s;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_sync <= 2'b11;  // line idles high
        end else begin
            rx_sync <= {rx_sync[0], rx};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            rx_byte <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_s) begin
                        state <= ST_START;
                    end
                end
                ST_START: begin
                    if (clk_cnt == HALF_LAST) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? ST_IDLE : ST_DATA;  // high again means a glitch
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                ST_DATA: begin
                    if (clk_cnt == BIT_LAST) begin
                        clk_cnt <= '0;
                        rx_byte <= {rx_s, rx_byte[7:1]};  // lsb first
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= ST_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: begin
                    if (clk_cnt == BIT_LAST) begin
                        clk_cnt <= '0;
                        state   <= ST_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase    <= PH_COUNT;
            n_words  <= '0;
            byte_cnt <= '0;
            word_cnt <= '0;
            word_sh  <= '0;
            done     <= 1'b0;
            load_wr  <= '0;
        end else begin
            load_wr.valid <= 1'b0;
            // done follows the last word's write pulse
            if (load_wr.valid && (word_cnt == n_words)) begin
                done <= 1'b1;
            end
            if (byte_done) begin
                if (phase == PH_COUNT) begin
                    // counts outside 1..16 are dropped
                    if ((rx_byte != 8'd0) && (rx_byte <= 8'(board_pkg::LOAD_DEPTH))) begin
                        n_words  <= rx_byte[4:0];
                        word_cnt <= '0;
                        byte_cnt <= '0;
                        done     <= 1'b0;
                        phase    <= PH_PAYLOAD;
                    end
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                    word_sh  <= {rx_byte, word_sh[23:8]};
                    if (byte_cnt == 2'd3) begin
                        load_wr.valid <= 1'b1;
                        load_wr.idx   <= word_cnt[3:0];
                        load_wr.data  <= {rx_byte, word_sh};
                        word_cnt      <= word_cnt + 5'd1;
                        if ((word_cnt + 5'd1) == n_words) begin
                            phase <= PH_COUNT;
                        end
                    end
                end
            end
        end
    end

    // no buffer write may land after the load has been flagged complete
    a_no_wr_after_done: assert property (
        @(posedge clk) disable iff (!arst_n) !(load_wr.valid && done)
    );

endmodule
